// File: design/bus_arbiter.sv
// wishbone arbiter for the walker and the data port
// registered grant held until ack, data port wins ties
`timescale 1ns/100ps
`include "mmu_consts.svh"

module bus_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           pw_cyc,
    input  mmu_pkg::word_t pw_adr,
    input  logic           up_cyc,
    input  logic           up_we,
    input  mmu_pkg::word_t up_adr,
    input  mmu_pkg::word_t up_dat_w,
    input  mmu_pkg::strb_t up_sel,
    output logic           pw_ack,
    output logic           up_ack,
    output mmu_pkg::word_t bus_rdat,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output mmu_pkg::word_t wb_adr,
    output mmu_pkg::word_t wb_dat_w,
    output mmu_pkg::strb_t wb_sel,
    input  mmu_pkg::word_t wb_dat_r,
    input  logic           wb_ack
);
    localparam logic [1:0] OWN_NONE = 2'd0;
    localparam logic [1:0] OWN_PW   = 2'd1;
    localparam logic [1:0] OWN_UP   = 2'd2;

    logic [1:0] owner;
    logic       own_up;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else if (owner == OWN_NONE) begin
            if (up_cyc)
                owner <= OWN_UP;  // data port first
            else if (pw_cyc)
                owner <= OWN_PW;
        end else if (wb_ack) begin
            owner <= OWN_NONE;    // release after the transfer
        end
    end

    assign own_up   = (owner == OWN_UP);
    assign wb_cyc   = (owner != OWN_NONE);
    assign wb_stb   = wb_cyc;
    assign wb_we    = own_up & up_we;                 // walker only reads
    assign wb_adr   = own_up ? up_adr : pw_adr;
    assign wb_dat_w = own_up ? up_dat_w : '0;
    assign wb_sel   = own_up ? up_sel : '1;
    assign pw_ack   = (owner == OWN_PW) & wb_ack;
    assign up_ack   = own_up & wb_ack;
    assign bus_rdat = wb_dat_r;

    ack_onehot_check: assert property (@(posedge clk) disable iff (rst)
        !(pw_ack && up_ack));

    // the granted peer keeps the bus lines steady through wait states
    bus_hold_check: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_we));

endmodule

// File: design/mmu_pkg.sv
// shared types of the memory management unit
// request ids, bus words and the page table entry decode
`include "mmu_consts.svh"

package mmu_pkg;

    typedef logic [`MMU_ID_W-1:0]   req_id_t; // zero means no request
    typedef logic [`MMU_XLEN-1:0]   word_t;   // address or data
    typedef logic [`MMU_STRB_W-1:0] strb_t;   // one bit per byte

    // a pte word seen two ways: as a pointer to the next table
    // or as a leaf whose ppn is split into segments for superpages
    typedef union packed {
        struct packed {
            logic [9:0]                 rsvd;
            logic [`MMU_PPN_W-1:0]      ppn;     // next level table
            logic [1:0]                 rsw;
            logic [7:0]                 flags;
        } ptr;
        struct packed {
            logic [9:0]                 rsvd;
            logic [7:0]                 ppn_top; // short top segment
            logic [3:0][`MMU_VPN_W-1:0] ppn_seg; // checked for superpages
            logic [1:0]                 rsw;
            logic [7:0]                 flags;
        } leaf;
    } pte_u;

endpackage

// File: design/mmu_top.sv
// reduced memory management unit
// page walker and uncached port sharing one wishbone master
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_top (
    input  logic             clk,
    input  logic             rst,
    input  mmu_pkg::req_id_t walk_rqst,
    input  mmu_pkg::word_t   walk_vadd,
    input  mmu_pkg::word_t   walk_satp,
    output mmu_pkg::req_id_t walk_resp,
    output logic [7:0]       walk_perm,
    output mmu_pkg::word_t   walk_padd,
    input  mmu_pkg::req_id_t data_rqst,
    input  mmu_pkg::word_t   data_addr,
    input  mmu_pkg::strb_t   data_strb,
    input  mmu_pkg::word_t   data_wdat,
    output mmu_pkg::req_id_t data_resp,
    output mmu_pkg::word_t   data_rdat,
    output logic             wb_cyc,
    output logic             wb_stb,
    output logic             wb_we,
    output mmu_pkg::word_t   wb_adr,
    output mmu_pkg::word_t   wb_dat_w,
    output mmu_pkg::strb_t   wb_sel,
    input  mmu_pkg::word_t   wb_dat_r,
    input  logic             wb_ack
);
    logic           pw_cyc;
    mmu_pkg::word_t pw_adr;
    logic           pw_ack;
    logic           up_cyc;
    logic           up_we;
    mmu_pkg::word_t up_adr;
    mmu_pkg::word_t up_dat_w;
    mmu_pkg::strb_t up_sel;
    logic           up_ack;
    mmu_pkg::word_t bus_rdat;    // shared read data

    page_walker u_walker (
        .clk(clk), .rst(rst),
        .walk_rqst(walk_rqst), .walk_vadd(walk_vadd), .walk_satp(walk_satp),
        .walk_resp(walk_resp), .walk_perm(walk_perm), .walk_padd(walk_padd),
        .pw_cyc(pw_cyc), .pw_adr(pw_adr), .pw_ack(pw_ack), .bus_rdat(bus_rdat)
    );

    uncached_port u_data (
        .clk(clk), .rst(rst),
        .data_rqst(data_rqst), .data_addr(data_addr), .data_wdat(data_wdat),
        .data_strb(data_strb), .data_resp(data_resp), .data_rdat(data_rdat),
        .up_cyc(up_cyc), .up_we(up_we), .up_adr(up_adr), .up_dat_w(up_dat_w),
        .up_sel(up_sel), .up_ack(up_ack), .bus_rdat(bus_rdat)
    );

    bus_arbiter u_arb (
        .clk(clk), .rst(rst),
        .pw_cyc(pw_cyc), .pw_adr(pw_adr),
        .up_cyc(up_cyc), .up_we(up_we), .up_adr(up_adr),
        .up_dat_w(up_dat_w), .up_sel(up_sel),
        .pw_ack(pw_ack), .up_ack(up_ack), .bus_rdat(bus_rdat),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

endmodule

// File: design/page_walker.sv
// page table walker for sv39, sv48 and sv57
// one translation at a time, one bus read per level
`timescale 1ns/100ps
`include "mmu_consts.svh"

module page_walker (
    input  logic             clk,
    input  logic             rst,
    input  mmu_pkg::req_id_t walk_rqst,
    input  mmu_pkg::word_t   walk_vadd,
    input  mmu_pkg::word_t   walk_satp,
    output mmu_pkg::req_id_t walk_resp,
    output logic [7:0]       walk_perm,
    output mmu_pkg::word_t   walk_padd,
    output logic             pw_cyc,
    output mmu_pkg::word_t   pw_adr,
    input  logic             pw_ack,
    input  mmu_pkg::word_t   bus_rdat
);
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1; // pte read on the bus
    localparam logic [1:0] ST_CHECK = 2'd2; // decode the fetched pte
    localparam logic [1:0] ST_DONE  = 2'd3; // response pulse

    logic [1:0]                 state;
    mmu_pkg::req_id_t           id_q;
    logic [4:0][`MMU_VPN_W-1:0] vpn_q;
    logic [`MMU_PPN_W-1:0]      ppn_q;   // table ppn, then result ppn
    logic [2:0]                 lvl_q;   // current level
    logic [7:0]                 perm_q;
    mmu_pkg::pte_u              pte_q;
    logic [3:0]                 mode;
    logic [`MMU_PPN_W-1:0]      leaf_ppn;
    logic                       misaligned;
    logic                       is_leaf;
    logic                       chk_fault;

    assign mode = walk_satp[`MMU_XLEN-1 -: 4];

    // superpage check and fill from the vpn
    always_comb begin
        leaf_ppn   = {pte_q.leaf.ppn_top, pte_q.leaf.ppn_seg};
        misaligned = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (i < int'(lvl_q)) begin
                if (|pte_q.leaf.ppn_seg[i])
                    misaligned = 1'b1;
                leaf_ppn[i*`MMU_VPN_W +: `MMU_VPN_W] = vpn_q[i];
            end
        end
    end

    always_comb begin
        is_leaf   = pte_q.ptr.flags[`MMU_PTE_R] | pte_q.ptr.flags[`MMU_PTE_X];
        chk_fault = ~pte_q.ptr.flags[`MMU_PTE_V]       // invalid entry
                  | (is_leaf & misaligned)             // bad superpage
                  | (~is_leaf & (lvl_q == 3'd0));      // no levels left
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|walk_rqst) begin
                        id_q  <= walk_rqst;
                        vpn_q <= walk_vadd[`MMU_PAGE_SHIFT +: 5*`MMU_VPN_W];
                        ppn_q <= walk_satp[`MMU_PPN_W-1:0]; // root table
                        state <= ST_READ;
                        case (mode)
                            `MMU_MODE_SV39: lvl_q <= 3'd2;
                            `MMU_MODE_SV48: lvl_q <= 3'd3;
                            `MMU_MODE_SV57: lvl_q <= 3'd4;
                            default: begin // unknown mode faults at once
                                perm_q <= '0;
                                ppn_q  <= '0;
                                state  <= ST_DONE;
                            end
                        endcase
                    end
                end
                ST_READ: begin
                    if (pw_ack) begin
                        pte_q <= bus_rdat;
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (chk_fault) begin
                        perm_q <= '0;
                        ppn_q  <= '0;
                        state  <= ST_DONE;
                    end else if (is_leaf) begin
                        perm_q <= pte_q.leaf.flags;
                        ppn_q  <= leaf_ppn;
                        state  <= ST_DONE;
                    end else begin
                        ppn_q <= pte_q.ptr.ppn; // descend one level
                        lvl_q <= lvl_q - 3'd1;
                        state <= ST_READ;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign pw_cyc    = (state == ST_READ);
    assign pw_adr    = {{(`MMU_XLEN-`MMU_PPN_W-`MMU_VPN_W-3){1'b0}},
                        ppn_q, vpn_q[lvl_q], 3'b000}; // 8-byte entries
    assign walk_resp = (state == ST_DONE) ? id_q : '0;
    assign walk_perm = perm_q;
    assign walk_padd = {{(`MMU_XLEN-`MMU_PPN_W-`MMU_PAGE_SHIFT){1'b0}},
                        ppn_q, {`MMU_PAGE_SHIFT{1'b0}}};

    // requester keeps its id until the matching response
    resp_id_check: assert property (@(posedge clk) disable iff (rst)
        |walk_resp |-> (walk_resp == id_q) && (walk_rqst == id_q));

    // a bus read only starts while a walk is pending
    cyc_start_check: assert property (@(posedge clk) disable iff (rst)
        $rose(pw_cyc) |-> $past(|walk_rqst));

endmodule

// File: design/uncached_port.sv
// uncached data port
// buffers one load or store and runs it as a single bus word
`timescale 1ns/100ps
`include "mmu_consts.svh"

module uncached_port (
    input  logic             clk,
    input  logic             rst,
    input  mmu_pkg::req_id_t data_rqst,
    input  mmu_pkg::word_t   data_addr,
    input  mmu_pkg::word_t   data_wdat,
    input  mmu_pkg::strb_t   data_strb,
    output mmu_pkg::req_id_t data_resp,
    output mmu_pkg::word_t   data_rdat,
    output logic             up_cyc,
    output logic             up_we,
    output mmu_pkg::word_t   up_adr,
    output mmu_pkg::word_t   up_dat_w,
    output mmu_pkg::strb_t   up_sel,
    input  logic             up_ack,
    input  mmu_pkg::word_t   bus_rdat
);
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUS  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0]       state;
    mmu_pkg::req_id_t id_q;
    mmu_pkg::word_t   rdat_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|data_rqst) begin
                        id_q     <= data_rqst;
                        up_we    <= |data_strb;           // nonzero strobe is a store
                        up_adr   <= {data_addr[`MMU_XLEN-1:3], 3'b000};
                        up_dat_w <= data_wdat;
                        up_sel   <= (|data_strb) ? data_strb : '1;
                        state    <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (up_ack) begin
                        rdat_q <= bus_rdat;               // valid in the ack cycle
                        state  <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign up_cyc    = (state == ST_BUS);
    assign data_resp = (state == ST_DONE) ? id_q : '0;
    assign data_rdat = rdat_q;

    // cycle and address held until the arbiter acks
    cyc_hold_check: assert property (@(posedge clk) disable iff (rst)
        up_cyc && !up_ack |=> up_cyc && $stable(up_adr));

endmodule

// File: include/mmu_consts.svh
// memory management unit constants
// widths, satp modes and page table entry bit positions
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// bus and word widths
`define MMU_XLEN        64
`define MMU_ID_W        8
`define MMU_STRB_W      8

// virtual and physical page numbers
`define MMU_VPN_W       9     // one vpn segment
`define MMU_PPN_W       44
`define MMU_PAGE_SHIFT  12    // 4 KiB pages

// satp mode field values
`define MMU_MODE_SV39   4'd8  // 3 levels
`define MMU_MODE_SV48   4'd9  // 4 levels
`define MMU_MODE_SV57   4'd10 // 5 levels

// pte flag bits
`define MMU_PTE_V       0
`define MMU_PTE_R       1
`define MMU_PTE_X       3

`endif

// File: run.sh
#!/bin/sh
# build and run the mmu testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module mmu_tb -Mdir obj_dir \
    && ./obj_dir/Vmmu_tb | grep -F "*** PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/mmu_tb.sv
// testbench for the reduced memory management unit
// page walks and uncached accesses against a wishbone memory model
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_tb;
    localparam int N_ITEMS    = 80;            // walks and data accesses issued
    localparam int WALK_WORST = 64;            // 5 levels with wait states and contention
    localparam int MAX_CYCLES = N_ITEMS * WALK_WORST;

    logic clk, rst;
    mmu_pkg::req_id_t walk_rqst, walk_resp, data_rqst, data_resp;
    mmu_pkg::word_t   walk_vadd, walk_satp, walk_padd, data_addr, data_wdat, data_rdat;
    mmu_pkg::strb_t   data_strb, wb_sel;
    logic [7:0]       walk_perm;
    logic             wb_cyc, wb_stb, wb_we, wb_ack;
    mmu_pkg::word_t   wb_adr, wb_dat_w, wb_dat_r;

    logic [63:0] mem [logic [63:0]];           // sparse word array
    logic [15:0] lfsr = 16'd20281;
    int walk_errs, data_errs, cycles;
    mmu_pkg::req_id_t exp_walk_id, exp_data_id;
    logic [7:0]  exp_perm;
    logic [63:0] exp_padd, exp_rdat;
    bit          exp_rdat_chk;
    logic [43:0] next_ppn = 44'h800;           // table allocator

    mmu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[62:0], lfsr_bit()};
        return v;
    endfunction

    // unwritten words read back a pattern with V clear
    function automatic logic [63:0] mem_read(input logic [63:0] a);
        if (mem.exists(a))
            return mem[a];
        return (a ^ 64'hA5C3_96E1_0F5A_3C78) & ~64'h1;
    endfunction

    function automatic logic [63:0] pte(input logic [43:0] ppn, input logic [7:0] flags);
        return {10'd0, ppn, 2'd0, flags};
    endfunction

    function automatic void ref_walk(input logic [63:0] vadd, input logic [63:0] satp,
                                     output logic [7:0] perm, output logic [63:0] padd);
        logic [43:0] ppn;
        logic [63:0] e;
        int lvl;
        perm = '0;
        padd = '0;
        case (satp[63:60])
            4'd8: lvl = 2;
            4'd9: lvl = 3;
            4'd10: lvl = 4;
            default: return;                   // unknown mode
        endcase
        ppn = satp[43:0];
        forever begin
            e = mem_read({8'd0, ppn, vadd[12+9*lvl +: 9], 3'b000});
            if (!e[0])
                return;
            if (e[1] || e[3]) begin
                ppn = e[53:10];
                for (int i = 0; i < lvl; i++) begin
                    if (ppn[9*i +: 9] != 0)
                        return;                // misaligned superpage
                    ppn[9*i +: 9] = vadd[12+9*i +: 9];
                end
                perm = e[7:0];
                padd = {8'd0, ppn, 12'd0};
                return;
            end
            if (lvl == 0)
                return;                        // pointer at the last level
            ppn = e[53:10];
            lvl--;
        end
    endfunction

    task automatic compare(input string name, input logic [63:0] got,
                           input logic [63:0] exp, input bit is_walk);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            if (is_walk)
                walk_errs++;
            else
                data_errs++;
        end
    endtask

    // memory slave with 0 to 3 wait states
    initial begin
        int wait_n;
        logic [63:0] w;
        wb_ack = 1'b0;
        wb_dat_r = '0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_cyc && wb_stb) begin
                wait_n = int'(rand_bits(2));
                repeat (wait_n) @(posedge clk);
                #1;
                w = mem_read(wb_adr);
                wb_dat_r = w;
                if (wb_we) begin
                    for (int b = 0; b < 8; b++)
                        if (wb_sel[b])
                            w[8*b +: 8] = wb_dat_w[8*b +: 8];
                    mem[wb_adr] = w;
                end
                wb_ack = 1'b1;
                @(posedge clk);
                #1 wb_ack = 1'b0;
            end
        end
    end

    // response checker
    always @(negedge clk) begin
        if (!rst && walk_resp !== '0) begin
            compare("walk_resp", walk_resp, exp_walk_id, 1'b1);
            compare("walk_perm", walk_perm, exp_perm, 1'b1);
            compare("walk_padd", walk_padd, exp_padd, 1'b1);
        end
        if (!rst && data_resp !== '0) begin
            compare("data_resp", data_resp, exp_data_id, 1'b0);
            if (exp_rdat_chk)
                compare("data_rdat", data_rdat, exp_rdat, 1'b0);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: a response did not arrive within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic do_walk(input logic [7:0] id, input logic [63:0] vadd,
                           input logic [63:0] satp);
        ref_walk(vadd, satp, exp_perm, exp_padd);
        exp_walk_id = id;
        walk_vadd = vadd;
        walk_satp = satp;
        walk_rqst = id;
        do @(negedge clk); while (walk_resp !== id);
        @(posedge clk);
        #1 walk_rqst = '0;
    endtask

    task automatic do_data(input logic [7:0] id, input logic [63:0] addr,
                           input logic [7:0] strb, input logic [63:0] wdat);
        logic [63:0] w;
        if (strb != 0) begin
            w = mem_read({addr[63:3], 3'b000});
            for (int b = 0; b < 8; b++)
                if (strb[b])
                    w[8*b +: 8] = wdat[8*b +: 8];
            exp_rdat = w;                      // merged bytes for the next read
        end
        exp_rdat_chk = (strb == 0);
        exp_data_id = id;
        data_addr = addr;
        data_strb = strb;
        data_wdat = wdat;
        data_rqst = id;
        do @(negedge clk); while (data_resp !== id);
        @(posedge clk);
        #1 data_rqst = '0;
    endtask

    // pointer chain down to a 4 KiB leaf under a fresh root
    task automatic build_chain(input logic [63:0] vadd, input int top, output logic [43:0] root);
        logic [43:0] ppn;
        root = next_ppn++;
        ppn = root;
        for (int lvl = top; lvl > 0; lvl--) begin
            mem[{8'd0, ppn, vadd[12+9*lvl +: 9], 3'b000}] = pte(next_ppn, 8'h01);
            ppn = next_ppn++;
        end
        mem[{8'd0, ppn, vadd[12 +: 9], 3'b000}] =
            pte(44'(rand_bits(20)), 8'(rand_bits(8)) | 8'h03);
    endtask

    initial begin
        logic [43:0] root;
        logic [63:0] va, a, d;
        logic [7:0]  s;
        rst = 1'b1;
        walk_rqst = '0;
        walk_vadd = '0;
        walk_satp = '0;
        data_rqst = '0;
        data_addr = '0;
        data_strb = '0;
        data_wdat = '0;
        exp_walk_id = '0;
        exp_data_id = '0;
        exp_perm = '0;
        exp_padd = '0;
        exp_rdat = '0;
        exp_rdat_chk = 1'b0;
        // sv39 tables under root 0x100
        mem[64'h100008] = pte(44'h101, 8'h01);
        mem[64'h101010] = pte(44'h102, 8'h01);
        mem[64'h102018] = pte(44'h5555, 8'hCF);
        mem[64'h101020] = pte(44'hA00, 8'h03);    // 2 MiB leaf
        mem[64'h100028] = pte(44'h40000, 8'h0B);  // 1 GiB leaf
        mem[64'h100030] = pte(44'h103, 8'h02);    // V clear
        mem[64'h100038] = pte(44'h40001, 8'h03);  // misaligned 1 GiB
        mem[64'h100040] = pte(44'h104, 8'h01);
        mem[64'h104000] = pte(44'h105, 8'h01);
        mem[64'h105000] = pte(44'h106, 8'h01);    // pointer at level 0
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        do_walk(8'd1, {25'd0, 9'd1, 9'd2, 9'd3, 12'h123}, {4'd8, 16'd0, 44'h100});
        do_walk(8'd2, {25'd0, 9'd1, 9'd4, 9'h1AB, 12'h0}, {4'd8, 16'd0, 44'h100});
        do_walk(8'd3, {25'd0, 9'd5, 9'h0F3, 9'h155, 12'h0}, {4'd8, 16'd0, 44'h100});
        do_walk(8'd4, {25'd0, 9'd1, 9'd2, 9'd3, 12'h0}, {4'd5, 16'd0, 44'h100});
        do_walk(8'd5, {25'd0, 9'd6, 18'd0, 12'h0}, {4'd8, 16'd0, 44'h100});
        do_walk(8'd6, {25'd0, 9'd7, 18'd0, 12'h0}, {4'd8, 16'd0, 44'h100});
        do_walk(8'd7, {25'd0, 9'd8, 18'd0, 12'h0}, {4'd8, 16'd0, 44'h100});
        do_walk(8'd8, {25'd0, 9'd9, 18'd0, 12'h0}, {4'd8, 16'd0, 44'h100}); // unmapped

        for (int i = 0; i < 16; i++) begin
            va = rand_bits(64);
            build_chain(va, 3, root);
            do_walk(8'(16 + i), va, {4'd9, 16'd0, root});
            va = rand_bits(64);
            build_chain(va, 4, root);
            do_walk(8'(48 + i), va, {4'd10, 16'd0, root});
        end

        for (int i = 0; i < 8; i++) begin
            a = 64'h8000_0000 + rand_bits(12);
            d = rand_bits(64);
            s = 8'(rand_bits(8));
            if (s == 0)
                s = 8'h01;
            do_data(8'(80 + i), a, s, d);
            do_data(8'(100 + i), a, 8'h00, '0);
        end

        // walk and data accesses in flight together
        for (int i = 0; i < 8; i++) begin
            va = rand_bits(64);
            build_chain(va, 4, root);
            a = 64'h9000_0000 + rand_bits(12);
            d = rand_bits(64);
            fork
                do_walk(8'(120 + i), va, {4'd10, 16'd0, root});
                begin
                    do_data(8'(140 + i), a, 8'hF0, d);
                    do_data(8'(160 + i), a, 8'h00, '0);
                end
            join
        end

        repeat (4) @(posedge clk);
        $display("errors: walk %0d data %0d", walk_errs, data_errs);
        if (walk_errs == 0 && data_errs == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/mmu_pkg.sv
design/page_walker.sv
design/uncached_port.sv
design/bus_arbiter.sv
design/mmu_top.sv
testbench/mmu_tb.sv
